// ==== tb.f ====
+incdir+design
design/queue_pkg.sv
design/reg_map_pkg.sv
design/queue_delta_tracker.sv
design/queue_stats_regs.sv
design/cpu_queue_regs_top.sv
verif/clk_gen.sv
verif/cpu_queue_regs_tb.sv

// ==== Makefile ====
# Verilator build and run of the queue register testbench

VERILATOR ?= verilator
TOP       ?= cpu_queue_regs_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(FILELIST) $(wildcard design/*.sv design/*.svh verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/cpu_queue_regs_tb.sv ====
/*
 * Testbench for the CPU queue statistics and control registers
 * directed tests over the four-phase host bus and both queue event ports,
 * checked against reference totals kept per register
 */
`timescale 1ns/1ps
`include "cpu_queue_params.svh"

module cpu_queue_regs_tb;

   localparam int CLK_PERIOD_NS     = 40;
   localparam int ACK_TIMEOUT       = 40;
   localparam int SETTLE_CYCLES     = 30;
   localparam int RAND_SEED         = 32'h7016a8f6;
   // cycle budgets per test
   localparam int BUDGET_RESET      = 150;
   localparam int BUDGET_CONTROL    = 100;
   localparam int BUDGET_TRAFFIC    = 400;
   localparam int BUDGET_CONCURRENT = 400;
   localparam int TOTAL_BUDGET      = BUDGET_RESET + BUDGET_CONTROL + 2 * BUDGET_TRAFFIC
                                      + BUDGET_CONCURRENT;

   logic                            clk;
   logic                            reset;
   logic                            reg_req;
   logic                            reg_write;
   logic [`CPUQ_BUS_ADDR_WIDTH-1:0] reg_addr;
   reg_map_pkg::reg_word_u          reg_wr_data;
   reg_map_pkg::reg_word_u          reg_rd_data;
   logic                            reg_ack;
   queue_pkg::queue_events_t        rx_events;
   queue_pkg::queue_events_t        tx_events;
   logic                            rx_queue_en;
   logic                            tx_queue_en;

   // reference register contents, CONTROL at index 0
   reg_map_pkg::reg_word_u exp_regs [0:`CPUQ_NUM_REGS-1];

   clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(5)) clock (
      .clk   (clk),
      .reset (reset)
   );

   cpu_queue_regs_top UUT (
      .clk         (clk),
      .reset       (reset),
      .reg_req     (reg_req),
      .reg_write   (reg_write),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_rd_data (reg_rd_data),
      .reg_ack     (reg_ack),
      .rx_events   (rx_events),
      .tx_events   (tx_events),
      .rx_queue_en (rx_queue_en),
      .tx_queue_en (tx_queue_en)
   );

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic check_word(input string name, input reg_map_pkg::reg_word_u actual,
                             input reg_map_pkg::reg_word_u expected);
      if (actual.value !== expected.value) begin
         $display("ERR time=%0t %s: got %08h expected %08h",
                  $time, name, actual.value, expected.value);
         $display("TEST FAILED");
         $fatal(1, "register value mismatch");
      end
   endtask

   // enables follow the disable bits of the control word
   task automatic check_control(input string name, input reg_map_pkg::control_t expected);
      logic [1:0] exp_en;
      logic [1:0] act_en;
      exp_en = {!expected.tx_disable, !expected.rx_disable};
      act_en = {tx_queue_en, rx_queue_en};
      if (act_en !== exp_en) begin
         $display("ERR time=%0t %s {tx_queue_en,rx_queue_en}: got %b expected %b",
                  $time, name, act_en, exp_en);
         $display("TEST FAILED");
         $fatal(1, "queue enable mismatch");
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("time=%0t %s", $time, what);
      $display("TEST FAILED");
      $fatal(1, "bus handshake timeout");
   endtask

   // ------------------------------
   // host bus, four-phase req/ack
   // ------------------------------
   task automatic bus_access(input logic write, input logic [`CPUQ_BUS_ADDR_WIDTH-1:0] addr,
                             input reg_map_pkg::reg_word_u wdata,
                             output reg_map_pkg::reg_word_u rdata);
      int cycles;
      @(posedge clk);
      reg_req     <= 1'b1;
      reg_write   <= write;
      reg_addr    <= addr;
      reg_wr_data <= wdata;
      cycles = 0;
      @(negedge clk);
      while (!reg_ack) begin
         cycles++;
         if (cycles > ACK_TIMEOUT)
            fail_timeout($sformatf("no ack from the DUT for address %02h", addr));
         @(negedge clk);
      end
      rdata = reg_rd_data;
      @(posedge clk);
      reg_req <= 1'b0;
      cycles = 0;
      @(negedge clk);
      while (reg_ack) begin
         cycles++;
         if (cycles > ACK_TIMEOUT)
            fail_timeout($sformatf("ack stayed high after the request for %02h", addr));
         @(negedge clk);
      end
   endtask

   task automatic bus_write(input logic [`CPUQ_BUS_ADDR_WIDTH-1:0] addr,
                            input reg_map_pkg::reg_word_u wdata);
      reg_map_pkg::reg_word_u unused;
      bus_access(1'b1, addr, wdata, unused);
   endtask

   task automatic bus_read(input logic [`CPUQ_BUS_ADDR_WIDTH-1:0] addr,
                           output reg_map_pkg::reg_word_u rdata);
      bus_access(1'b0, addr, '0, rdata);
   endtask

   task automatic read_check(input logic [`CPUQ_BUS_ADDR_WIDTH-1:0] addr, input string name,
                             input reg_map_pkg::reg_word_u expected);
      reg_map_pkg::reg_word_u rdata;
      bus_read(addr, rdata);
      check_word(name, rdata, expected);
   endtask

   task automatic read_check_reg(input int idx);
      reg_map_pkg::reg_addr_e a;
      a = reg_map_pkg::reg_addr_e'(4'(idx));
      read_check({4'b0000, 4'(idx)}, $sformatf("reg_rd_data@%s", a.name()), exp_regs[idx]);
   endtask

   task automatic check_all_regs();
      int idx;
      for (idx = 0; idx < `CPUQ_NUM_REGS; idx++)
         read_check_reg(idx);
   endtask

   // ------------------------------
   // queue events and reference totals
   // ------------------------------
   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic drive_event(input bit rx, input logic stored, input logic removed,
                              input logic overrun, input logic [`CPUQ_BYTE_CNT_WIDTH-1:0] bytes);
      queue_pkg::queue_events_t ev;
      int base;
      ev.stored   = stored;
      ev.removed  = removed;
      ev.overrun  = overrun;
      ev.byte_cnt = bytes;
      base = rx ? 1 : 6;
      @(posedge clk);
      if (rx)
         rx_events <= ev;
      else
         tx_events <= ev;
      @(posedge clk);
      if (rx)
         rx_events <= '0;
      else
         tx_events <= '0;
      if (stored)
         exp_regs[base].value = exp_regs[base].value + 32'd1;
      if (removed)
         exp_regs[base + 1].value = exp_regs[base + 1].value + 32'd1;
      // occupancy moves only on a lone store or a lone removal
      if (stored && !removed)
         exp_regs[base + 2].value = exp_regs[base + 2].value + 32'd1;
      else if (removed && !stored)
         exp_regs[base + 2].value = exp_regs[base + 2].value - 32'd1;
      // rx counts bytes leaving, tx counts bytes entering
      if (rx ? removed : stored)
         exp_regs[base + 3].value = exp_regs[base + 3].value + {20'd0, bytes};
      if (overrun)
         exp_regs[base + 4].value = exp_regs[base + 4].value + 32'd1;
   endtask

   // stores and removals each at least 8 cycles apart
   task automatic inject_traffic(input bit rx, input int n_store, input int n_remove,
                                 input bit overlap);
      int  i;
      int  n_removed;
      bit  both;
      n_removed = 0;
      for (i = 0; i < n_store; i++) begin
         both = overlap && (i == 5);
         if (both)
            idle_cycles(5);
         drive_event(rx, 1'b1, both, 1'($urandom_range(1)), 12'($urandom_range(2047)));
         if (both)
            n_removed++;
         idle_cycles(3);
         if (!both && n_removed < n_remove) begin
            drive_event(rx, 1'b0, 1'b1, 1'($urandom_range(1)), 12'($urandom_range(2047)));
            n_removed++;
         end
         idle_cycles(3);
      end
   endtask

   // ------------------------------
   // directed tests
   // ------------------------------
   task automatic test_reset_state();
      reg_map_pkg::reg_word_u bad;
      bad.value = `CPUQ_BAD_ADDR_DATA;
      check_all_regs();
      check_control("after reset", exp_regs[0].ctrl);
      read_check(8'd11, "reg_rd_data@0x0b", bad);
      read_check(8'h41, "reg_rd_data@0x41", bad);
   endtask

   task automatic test_control();
      int i;
      reg_map_pkg::reg_word_u w;
      // rx off, tx off, both off, then both back on
      for (i = 1; i <= 4; i++) begin
         w.value = '0;
         w.ctrl.rx_disable = i[0];
         w.ctrl.tx_disable = i[1];
         exp_regs[0] = w;
         bus_write(8'd0, w);
         read_check_reg(0);
         check_control($sformatf("control write %0d", i % 4), w.ctrl);
      end
   endtask

   task automatic test_traffic(input bit rx, input bit overlap);
      inject_traffic(rx, 20, 14, overlap);
      idle_cycles(SETTLE_CYCLES);
      check_all_regs();
   endtask

   task automatic test_counter_write();
      int k;
      int idx;
      reg_map_pkg::reg_word_u w;
      w.value = $urandom;
      exp_regs[1] = w;
      bus_write(8'd1, w);
      // rx events while the host reads tx registers and CONTROL
      fork
         inject_traffic(1'b1, 8, 8, 1'b0);
         for (k = 0; k < 15; k++) begin
            idx = (k % 6 == 0) ? 0 : 5 + k % 6;
            read_check_reg(idx);
         end
      join
      idle_cycles(SETTLE_CYCLES);
      check_all_regs();
      // writes outside the map change nothing
      w.value = '1;
      bus_write(8'h80, w);
      w.value = $urandom;
      bus_write(8'd13, w);
      check_all_regs();
      check_control("after bad writes", exp_regs[0].ctrl);
   endtask

   // ------------------------------
   // watchdog and main sequence
   // ------------------------------
   initial begin
      #(TOTAL_BUDGET * 3 / 2 * CLK_PERIOD_NS);
      $display("time=%0t the run hung and did not finish within its cycle budget", $time);
      $display("TEST FAILED");
      $fatal(1, "watchdog timeout");
   end

   initial begin
      reg_req     = 1'b0;
      reg_write   = 1'b0;
      reg_addr    = '0;
      reg_wr_data = '0;
      rx_events   = '0;
      tx_events   = '0;
      for (int i = 0; i < `CPUQ_NUM_REGS; i++)
         exp_regs[i] = '0;
      void'($urandom(RAND_SEED));
      wait (reset == 1'b0);
      test_reset_state();
      test_control();
      test_traffic(1'b1, 1'b0);
      test_traffic(1'b0, 1'b1);
      test_counter_write();
      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== verif/clk_gen.sv ====
/*
 * Testbench clock and reset source
 * free running clock, reset held high for the first few cycles
 */
`timescale 1ns/1ps

module clk_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

// ==== design/cpu_queue_regs_top.sv ====
/*
 * CPU DMA queue pair statistics and control registers
 * rx and tx delta trackers feeding one register controller
 */
`timescale 1ns/1ps
`include "cpu_queue_params.svh"

module cpu_queue_regs_top (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            reg_req,
   input  logic                            reg_write,
   input  logic [`CPUQ_BUS_ADDR_WIDTH-1:0] reg_addr,
   input  reg_map_pkg::reg_word_u          reg_wr_data,
   output reg_map_pkg::reg_word_u          reg_rd_data,
   output logic                            reg_ack,
   input  queue_pkg::queue_events_t        rx_events,
   input  queue_pkg::queue_events_t        tx_events,
   output logic                            rx_queue_en,
   output logic                            tx_queue_en
);

   queue_pkg::queue_deltas_t rx_deltas;
   queue_pkg::queue_deltas_t tx_deltas;
   queue_pkg::queue_clear_t  rx_clear;
   queue_pkg::queue_clear_t  tx_clear;

   // rx counts bytes on removal
   queue_delta_tracker #(.count_bytes_on_store(1'b0)) rx_tracker (
      .clk    (clk),
      .reset  (reset),
      .events (rx_events),
      .clear  (rx_clear),
      .deltas (rx_deltas)
   );

   // tx counts bytes on store
   queue_delta_tracker #(.count_bytes_on_store(1'b1)) tx_tracker (
      .clk    (clk),
      .reset  (reset),
      .events (tx_events),
      .clear  (tx_clear),
      .deltas (tx_deltas)
   );

   queue_stats_regs stats_regs (
      .clk         (clk),
      .reset       (reset),
      .reg_req     (reg_req),
      .reg_write   (reg_write),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_rd_data (reg_rd_data),
      .reg_ack     (reg_ack),
      .rx_deltas   (rx_deltas),
      .tx_deltas   (tx_deltas),
      .rx_clear    (rx_clear),
      .tx_clear    (tx_clear),
      .rx_queue_en (rx_queue_en),
      .tx_queue_en (tx_queue_en)
   );

endmodule

// ==== design/queue_stats_regs.sv ====
/*
 * Queue statistics register controller
 * clears the register file after reset, then sweeps the counters adding
 * pending deltas, serves four-phase host accesses and holds the control word
 */
`timescale 1ns/1ps
`include "cpu_queue_params.svh"

module queue_stats_regs (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            reg_req,
   input  logic                            reg_write,
   input  logic [`CPUQ_BUS_ADDR_WIDTH-1:0] reg_addr,
   input  reg_map_pkg::reg_word_u          reg_wr_data,
   output reg_map_pkg::reg_word_u          reg_rd_data,
   output logic                            reg_ack,
   input  queue_pkg::queue_deltas_t        rx_deltas,
   input  queue_pkg::queue_deltas_t        tx_deltas,
   output queue_pkg::queue_clear_t         rx_clear,
   output queue_pkg::queue_clear_t         tx_clear,
   output logic                            rx_queue_en,
   output logic                            tx_queue_en
);

   localparam int DW = `CPUQ_DATA_WIDTH;
   localparam int AW = `CPUQ_BUS_ADDR_WIDTH;
   localparam int RW = `CPUQ_REG_ADDR_WIDTH;
   localparam int BW = `CPUQ_BYTE_DELTA_WIDTH;
   localparam logic [RW-1:0] NUM_REGS = `CPUQ_NUM_REGS;
   localparam logic [RW-1:0] LAST_IDX = NUM_REGS - 1'b1;

   typedef enum logic {INIT, SWEEP} state_e;

   logic [DW-1:0]         reg_file [0:`CPUQ_NUM_REGS-1];
   logic                  ram_wr;
   logic [RW-1:0]         ram_addr;
   logic [DW-1:0]         ram_wdata;
   logic [DW-1:0]         ram_rdata;
   state_e                state;
   state_e                state_nxt;
   logic [RW-1:0]         sweep_idx;
   logic [RW-1:0]         sweep_idx_nxt;
   reg_map_pkg::control_t control;
   logic [RW-1:0]         addr_idx;
   logic                  addr_good;
   logic                  is_control;
   logic                  access;
   logic                  commit;
   logic [DW-1:0]         commit_delta;

   // ------------------------------
   // address decode and handshake
   // ------------------------------
   assign addr_idx   = reg_addr[RW-1:0];
   assign addr_good  = (reg_addr[AW-1:RW] == '0) && (addr_idx < NUM_REGS);
   assign is_control = addr_idx == reg_map_pkg::CONTROL;

   // ack stays high until req is seen low, so a high ack marks a served request
   assign access = (state == SWEEP) && reg_req && !reg_ack;
   assign commit = (state == SWEEP) && !access;

   assign rx_queue_en = !control.rx_disable;
   assign tx_queue_en = !control.tx_disable;

   // ------------------------------
   // register file RAM
   // ------------------------------
   assign ram_addr  = (access && addr_good) ? addr_idx : sweep_idx;
   assign ram_rdata = reg_file[ram_addr];

   always_ff @(posedge clk) begin
      if (ram_wr)
         reg_file[ram_addr] <= ram_wdata;
   end

   // ------------------------------
   // commit sweep delta select
   // ------------------------------
   // in_queue is the only signed delta
   always_comb begin
      case (reg_map_pkg::reg_addr_e'(sweep_idx))
         reg_map_pkg::RX_PKTS_ENQUEUED: commit_delta = {{(DW-2){1'b0}}, rx_deltas.stored};
         reg_map_pkg::RX_PKTS_DEQUEUED: commit_delta = {{(DW-2){1'b0}}, rx_deltas.removed};
         reg_map_pkg::RX_PKTS_IN_QUEUE:
            commit_delta = {{(DW-3){rx_deltas.in_queue[2]}}, rx_deltas.in_queue};
         reg_map_pkg::RX_BYTES_PUSHED:  commit_delta = {{(DW-BW){1'b0}}, rx_deltas.bytes};
         reg_map_pkg::RX_OVERRUNS:      commit_delta = {{(DW-4){1'b0}}, rx_deltas.overruns};
         reg_map_pkg::TX_PKTS_ENQUEUED: commit_delta = {{(DW-2){1'b0}}, tx_deltas.stored};
         reg_map_pkg::TX_PKTS_DEQUEUED: commit_delta = {{(DW-2){1'b0}}, tx_deltas.removed};
         reg_map_pkg::TX_PKTS_IN_QUEUE:
            commit_delta = {{(DW-3){tx_deltas.in_queue[2]}}, tx_deltas.in_queue};
         reg_map_pkg::TX_BYTES_PUSHED:  commit_delta = {{(DW-BW){1'b0}}, tx_deltas.bytes};
         reg_map_pkg::TX_OVERRUNS:      commit_delta = {{(DW-4){1'b0}}, tx_deltas.overruns};
         default:                       commit_delta = '0;
      endcase
   end

   // clear strobe for the field being committed
   assign rx_clear.stored   = commit && (sweep_idx == reg_map_pkg::RX_PKTS_ENQUEUED);
   assign rx_clear.removed  = commit && (sweep_idx == reg_map_pkg::RX_PKTS_DEQUEUED);
   assign rx_clear.in_queue = commit && (sweep_idx == reg_map_pkg::RX_PKTS_IN_QUEUE);
   assign rx_clear.bytes    = commit && (sweep_idx == reg_map_pkg::RX_BYTES_PUSHED);
   assign rx_clear.overruns = commit && (sweep_idx == reg_map_pkg::RX_OVERRUNS);
   assign tx_clear.stored   = commit && (sweep_idx == reg_map_pkg::TX_PKTS_ENQUEUED);
   assign tx_clear.removed  = commit && (sweep_idx == reg_map_pkg::TX_PKTS_DEQUEUED);
   assign tx_clear.in_queue = commit && (sweep_idx == reg_map_pkg::TX_PKTS_IN_QUEUE);
   assign tx_clear.bytes    = commit && (sweep_idx == reg_map_pkg::TX_BYTES_PUSHED);
   assign tx_clear.overruns = commit && (sweep_idx == reg_map_pkg::TX_OVERRUNS);

   // ------------------------------
   // FSM
   // ------------------------------
   always_comb begin
      state_nxt     = state;
      sweep_idx_nxt = sweep_idx;
      ram_wr        = 1'b0;
      ram_wdata     = ram_rdata + commit_delta;
      case (state)
         INIT: begin
            // zero every word once
            ram_wr    = 1'b1;
            ram_wdata = '0;
            if (sweep_idx == LAST_IDX) begin
               state_nxt     = SWEEP;
               sweep_idx_nxt = '0;
            end else begin
               sweep_idx_nxt = sweep_idx + 1'b1;
            end
         end
         SWEEP: begin
            if (access) begin
               // sweep index holds during a host access
               ram_wr    = addr_good && reg_write;
               ram_wdata = reg_wr_data.value;
            end else begin
               ram_wr        = 1'b1;
               sweep_idx_nxt = (sweep_idx == LAST_IDX) ? '0 : sweep_idx + 1'b1;
            end
         end
         default: state_nxt = INIT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= INIT;
         sweep_idx   <= '0;
         control     <= '0;
         reg_ack     <= 1'b0;
         reg_rd_data <= '0;
      end else begin
         state     <= state_nxt;
         sweep_idx <= sweep_idx_nxt;
         if (access) begin
            reg_ack <= 1'b1;
            if (!addr_good)
               reg_rd_data.value <= `CPUQ_BAD_ADDR_DATA;
            else if (is_control)
               reg_rd_data.ctrl <= control;
            else
               reg_rd_data.value <= ram_rdata;
            if (addr_good && is_control && reg_write)
               control <= reg_wr_data.ctrl;
         end else if (!reg_req) begin
            reg_ack <= 1'b0;
         end
      end
   end

endmodule

// ==== design/queue_delta_tracker.sv ====
/*
 * Queue delta tracker
 * gathers one queue's events into small delta counters that the
 * register controller commits and clears one field at a time
 */
`timescale 1ns/1ps
`include "cpu_queue_params.svh"

module queue_delta_tracker #(
   parameter bit count_bytes_on_store = 1'b0
) (
   input  logic                     clk,
   input  logic                     reset,
   input  queue_pkg::queue_events_t events,
   input  queue_pkg::queue_clear_t  clear,
   output queue_pkg::queue_deltas_t deltas
);

   localparam int BW = `CPUQ_BYTE_DELTA_WIDTH;
   localparam int CW = `CPUQ_BYTE_CNT_WIDTH;

   logic              byte_strobe;
   logic [1:0]        stored_inc;
   logic [1:0]        removed_inc;
   logic signed [2:0] in_queue_step;
   logic [BW-1:0]     bytes_inc;
   logic [3:0]        overrun_inc;

   // ------------------------------
   // this cycle's contribution
   // ------------------------------
   // tx counts bytes going in, rx counts bytes going out
   assign byte_strobe = count_bytes_on_store ? events.stored : events.removed;

   assign stored_inc  = {1'b0, events.stored};
   assign removed_inc = {1'b0, events.removed};
   assign overrun_inc = {3'b000, events.overrun};
   assign bytes_inc   = byte_strobe ? {{(BW-CW){1'b0}}, events.byte_cnt} : '0;

   // store and remove together leave the occupancy alone
   always_comb begin
      case ({events.removed, events.stored})
         2'b01:   in_queue_step = 3'sd1;
         2'b10:   in_queue_step = -3'sd1;
         default: in_queue_step = 3'sd0;
      endcase
   end

   // ------------------------------
   // delta registers
   // ------------------------------
   // a cleared field restarts from this cycle's contribution
   always_ff @(posedge clk) begin
      if (reset) begin
         deltas <= '0;
      end else begin
         if (clear.stored)
            deltas.stored <= stored_inc;
         else
            deltas.stored <= deltas.stored + stored_inc;

         if (clear.removed)
            deltas.removed <= removed_inc;
         else
            deltas.removed <= deltas.removed + removed_inc;

         if (clear.in_queue)
            deltas.in_queue <= in_queue_step;
         else
            deltas.in_queue <= deltas.in_queue + in_queue_step;

         if (clear.bytes)
            deltas.bytes <= bytes_inc;
         else
            deltas.bytes <= deltas.bytes + bytes_inc;

         if (clear.overruns)
            deltas.overruns <= overrun_inc;
         else
            deltas.overruns <= deltas.overruns + overrun_inc;
      end
   end

endmodule

// ==== design/reg_map_pkg.sv ====
/*
 * Register map types
 * register addresses, control word fields and the host data word
 */
`include "cpu_queue_params.svh"

package reg_map_pkg;

   // ------------------------------
   // register addresses
   // ------------------------------
   typedef enum logic [`CPUQ_REG_ADDR_WIDTH-1:0] {
      CONTROL          = 4'd0,
      RX_PKTS_ENQUEUED = 4'd1,
      RX_PKTS_DEQUEUED = 4'd2,
      RX_PKTS_IN_QUEUE = 4'd3,
      RX_BYTES_PUSHED  = 4'd4,
      RX_OVERRUNS      = 4'd5,
      TX_PKTS_ENQUEUED = 4'd6,
      TX_PKTS_DEQUEUED = 4'd7,
      TX_PKTS_IN_QUEUE = 4'd8,
      TX_BYTES_PUSHED  = 4'd9,
      TX_OVERRUNS      = 4'd10
   } reg_addr_e;

   // ------------------------------
   // control word
   // ------------------------------
   typedef struct packed {
      logic [`CPUQ_DATA_WIDTH-3:0] reserved;
      logic                        tx_disable;
      logic                        rx_disable;
   } control_t;

   // host word, seen as a counter value or as control fields
   typedef union packed {
      logic [`CPUQ_DATA_WIDTH-1:0] value;
      control_t                    ctrl;
   } reg_word_u;

endpackage

// ==== design/queue_pkg.sv ====
/*
 * Queue side types
 * per-cycle queue events, pending deltas and their clear strobes
 */
`include "cpu_queue_params.svh"

package queue_pkg;

   // one cycle of activity on a queue
   typedef struct packed {
      logic                            stored;
      logic                            removed;
      logic                            overrun;
      logic [`CPUQ_BYTE_CNT_WIDTH-1:0] byte_cnt;
   } queue_events_t;

   // increments not yet added into the register file
   typedef struct packed {
      logic [1:0]                        stored;
      logic [1:0]                        removed;
      logic signed [2:0]                 in_queue;
      logic [`CPUQ_BYTE_DELTA_WIDTH-1:0] bytes;
      logic [3:0]                        overruns;
   } queue_deltas_t;

   // one strobe per delta field, high in its commit cycle
   typedef struct packed {
      logic stored;
      logic removed;
      logic in_queue;
      logic bytes;
      logic overruns;
   } queue_clear_t;

endpackage

// ==== design/cpu_queue_params.svh ====
/*
 * CPU queue register block parameters
 * widths, register count and the unmapped-address read word
 */
`ifndef CPUQ_PARAMS_SVH
`define CPUQ_PARAMS_SVH

// host bus
`define CPUQ_DATA_WIDTH        32
`define CPUQ_BUS_ADDR_WIDTH    8

// register file
`define CPUQ_NUM_REGS          11
`define CPUQ_REG_ADDR_WIDTH    4

// per packet byte count and its delta (two packets per sweep)
`define CPUQ_BYTE_CNT_WIDTH    12
`define CPUQ_BYTE_DELTA_WIDTH  13

// returned for reads outside the register map
`define CPUQ_BAD_ADDR_DATA     32'hdead_beef

`endif
